/* design/cpu_pkg.sv */
package cpu_pkg;

    // primary opcodes, MIPS encoding
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type function field
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_sra = 6'h03;
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2a;

    // alu operations, decode to execute
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_xor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5;
    localparam logic [3:0] alu_sll = 4'd6;
    localparam logic [3:0] alu_srl = 4'd7;
    localparam logic [3:0] alu_sra = 4'd8;
    localparam logic [3:0] alu_lui = 4'd9;

    // destination select, other codes held back for a link register
    localparam logic [2:0] regdst_rt = 3'd0;
    localparam logic [2:0] regdst_rd = 3'd1;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, read both ways by decode
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] reg_data1;
        logic [31:0] reg_data2;
        logic [31:0] imm_ext;
        logic [4:0]  rd;
        logic [4:0]  rt;
        logic [5:0]  func;
        logic [4:0]  shamt;
        logic        alusrc;   // 1 selects imm_ext
        logic [2:0]  regdst;
        logic        regwrite;
        logic [3:0]  aluop;
        logic        memwrite;
        logic        memread;
        logic        memtoreg;
    } id_bundle_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } wb_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic        regwrite;
        logic        memwrite;
        logic        memread;
        logic        memtoreg;
    } ex_out_t;

endpackage

/* design/decode_stage.sv */
`timescale 1ns/100ps
module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic [31:0]         pc,
    input  cpu_pkg::instr_u     instr,
    input  cpu_pkg::wb_t        wb,
    output cpu_pkg::id_bundle_t id_bus
);

    logic [31:0] regs [0:31];
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        sext;   // sign-extend the immediate

    // register file, written at the edge, no bypass on read
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.wen && (wb.waddr != 5'd0)) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    assign rs = instr.i_fields.rs;
    assign rt = instr.i_fields.rt;

    assign rdata1 = (rs == 5'd0) ? 32'd0 : regs[rs];   // r0 hardwired
    assign rdata2 = (rt == 5'd0) ? 32'd0 : regs[rt];

    always_comb begin
        id_bus = '0;   // unknown codes leave a bubble
        sext   = 1'b0;

        id_bus.pc        = pc;
        id_bus.reg_data1 = rdata1;
        id_bus.reg_data2 = rdata2;
        id_bus.rd        = instr.r_fields.rd;
        id_bus.rt        = rt;
        id_bus.func      = instr.r_fields.func;
        id_bus.shamt     = instr.r_fields.shamt;

        case (instr.i_fields.opcode)
            cpu_pkg::op_rtype: begin
                id_bus.regdst   = cpu_pkg::regdst_rd;
                id_bus.regwrite = 1'b1;
                case (instr.r_fields.func)
                    cpu_pkg::fn_add: id_bus.aluop = cpu_pkg::alu_add;
                    cpu_pkg::fn_sub: id_bus.aluop = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: id_bus.aluop = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:  id_bus.aluop = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor: id_bus.aluop = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt: id_bus.aluop = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sll: id_bus.aluop = cpu_pkg::alu_sll;
                    cpu_pkg::fn_srl: id_bus.aluop = cpu_pkg::alu_srl;
                    cpu_pkg::fn_sra: id_bus.aluop = cpu_pkg::alu_sra;
                    default: begin
                        id_bus.regdst   = cpu_pkg::regdst_rt;
                        id_bus.regwrite = 1'b0;
                    end
                endcase
            end
            cpu_pkg::op_addi: begin
                sext            = 1'b1;
                id_bus.alusrc   = 1'b1;
                id_bus.regwrite = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_add;
            end
            cpu_pkg::op_slti: begin
                sext            = 1'b1;
                id_bus.alusrc   = 1'b1;
                id_bus.regwrite = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_slt;
            end
            cpu_pkg::op_andi: begin   // logic ops zero-extend
                id_bus.alusrc   = 1'b1;
                id_bus.regwrite = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_and;
            end
            cpu_pkg::op_ori: begin
                id_bus.alusrc   = 1'b1;
                id_bus.regwrite = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_or;
            end
            cpu_pkg::op_lui: begin
                id_bus.alusrc   = 1'b1;
                id_bus.regwrite = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_lui;
            end
            cpu_pkg::op_lw: begin
                sext            = 1'b1;
                id_bus.alusrc   = 1'b1;
                id_bus.regwrite = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_add;   // base plus offset
                id_bus.memread  = 1'b1;
                id_bus.memtoreg = 1'b1;
            end
            cpu_pkg::op_sw: begin
                sext            = 1'b1;
                id_bus.alusrc   = 1'b1;
                id_bus.aluop    = cpu_pkg::alu_add;
                id_bus.memwrite = 1'b1;
            end
            default: ;
        endcase

        id_bus.imm_ext = {{16{sext & instr.i_fields.imm[15]}}, instr.i_fields.imm};
    end

endmodule

/* design/id_ex.sv */
`timescale 1ns/100ps
module id_ex (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::id_bundle_t id_bus,
    output cpu_pkg::id_bundle_t ex_bus
);

    // stage boundary between decode and execute
    // data and control move together every cycle, no stall
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_bus <= '0;   // all control low, a bubble
        end else begin
            ex_bus <= id_bus;
        end
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps
module execute_stage (
    input  cpu_pkg::id_bundle_t ex_bus,
    output cpu_pkg::ex_out_t    ex
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        less;     // signed compare for slt
    logic [31:0] result;

    assign op_a = ex_bus.reg_data1;
    assign op_b = ex_bus.alusrc ? ex_bus.imm_ext : ex_bus.reg_data2;

    assign less = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex_bus.aluop)
            cpu_pkg::alu_add: result = op_a + op_b;
            cpu_pkg::alu_sub: result = op_a - op_b;
            cpu_pkg::alu_and: result = op_a & op_b;
            cpu_pkg::alu_or:  result = op_a | op_b;
            cpu_pkg::alu_xor: result = op_a ^ op_b;
            cpu_pkg::alu_slt: result = {31'd0, less};
            // shifts act on the rt value by shamt
            cpu_pkg::alu_sll: result = ex_bus.reg_data2 << ex_bus.shamt;
            cpu_pkg::alu_srl: result = ex_bus.reg_data2 >> ex_bus.shamt;
            cpu_pkg::alu_sra: result = $signed(ex_bus.reg_data2) >>> ex_bus.shamt;
            cpu_pkg::alu_lui: result = {ex_bus.imm_ext[15:0], 16'd0};
            default:          result = 32'd0;
        endcase
    end

    always_comb begin
        ex.alu_result = result;
        ex.store_data = ex_bus.reg_data2;   // sw data comes from rt
        case (ex_bus.regdst)
            cpu_pkg::regdst_rd: ex.dest = ex_bus.rd;
            cpu_pkg::regdst_rt: ex.dest = ex_bus.rt;
            default:            ex.dest = ex_bus.rt;   // reserved codes
        endcase
        ex.regwrite = ex_bus.regwrite;
        ex.memwrite = ex_bus.memwrite;
        ex.memread  = ex_bus.memread;
        ex.memtoreg = ex_bus.memtoreg;
    end

endmodule

/* design/id_ex_path.sv */
`timescale 1ns/100ps
module id_ex_path (
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      pc,
    input  cpu_pkg::instr_u  instr,
    input  cpu_pkg::wb_t     wb,
    output cpu_pkg::ex_out_t ex
);

    cpu_pkg::id_bundle_t id_bus;   // decode output, combinational
    cpu_pkg::id_bundle_t ex_bus;   // registered copy for execute

    decode_stage i_decode_stage (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .instr  (instr),
        .wb     (wb),
        .id_bus (id_bus)
    );

    id_ex i_id_ex (
        .clk    (clk),
        .reset  (reset),
        .id_bus (id_bus),
        .ex_bus (ex_bus)
    );

    // one cycle from instr to ex
    execute_stage i_execute_stage (
        .ex_bus (ex_bus),
        .ex     (ex)
    );

endmodule

/* test/id_ex_path_asserts.sv */
`timescale 1ns/100ps
module id_ex_path_asserts (
    input logic             clk,
    input logic             reset,
    input cpu_pkg::ex_out_t ex
);

    // id_ex cleared, so execute sees a bubble
    reset_bubble: assert property (@(posedge clk)
        reset |=> !(ex.regwrite || ex.memwrite || ex.memread || ex.memtoreg))
        else $error("control bits set in the cycle after reset");

    load_writeback: assert property (@(posedge clk) disable iff (reset)
        ex.memread |-> (ex.memtoreg && ex.regwrite))
        else $error("load without memtoreg and regwrite");

    store_no_write: assert property (@(posedge clk) disable iff (reset)
        ex.memwrite |-> !ex.regwrite)
        else $error("store also writes a register");

    mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ex.memread && ex.memwrite))
        else $error("memread and memwrite high together");

endmodule

bind id_ex_path id_ex_path_asserts i_id_ex_path_asserts (
    .clk   (clk),
    .reset (reset),
    .ex    (ex)
);

/* test/id_ex_path_tb.sv */
`timescale 1ns/100ps
module id_ex_path_tb;

    logic             clk;
    logic             reset;
    logic [31:0]      pc;
    cpu_pkg::instr_u  instr;
    cpu_pkg::wb_t     wb;
    cpu_pkg::ex_out_t ex;

    cpu_pkg::ex_out_t exp_ex;         // expected result of the instruction in flight
    logic [31:0]      shadow [0:31];  // model register file
    int               cycles;
    int               errors;
    int               num_instr = 400;
    int               max_cycles = 1000;

    logic [5:0] opcodes [0:7] = '{cpu_pkg::op_rtype, cpu_pkg::op_addi, cpu_pkg::op_andi,
        cpu_pkg::op_ori, cpu_pkg::op_slti, cpu_pkg::op_lui, cpu_pkg::op_lw, cpu_pkg::op_sw};
    logic [5:0] funcs [0:8] = '{cpu_pkg::fn_add, cpu_pkg::fn_sub, cpu_pkg::fn_and,
        cpu_pkg::fn_or, cpu_pkg::fn_xor, cpu_pkg::fn_slt, cpu_pkg::fn_sll, cpu_pkg::fn_srl,
        cpu_pkg::fn_sra};

    id_ex_path i_id_ex_path (
        .clk   (clk),
        .reset (reset),
        .pc    (pc),
        .instr (instr),
        .wb    (wb),
        .ex    (ex)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected execute output, straight from the instruction set rules
    function automatic cpu_pkg::ex_out_t model_ex(cpu_pkg::instr_u ins, logic [31:0] a,
                                                  logic [31:0] b);
        cpu_pkg::ex_out_t e;
        logic [31:0]      simm;
        logic [31:0]      zimm;
        e = '0;
        simm = {{16{ins.i_fields.imm[15]}}, ins.i_fields.imm};
        zimm = {16'd0, ins.i_fields.imm};
        e.store_data = b;
        e.dest = ins.i_fields.rt;
        e.regwrite = 1'b1;
        case (ins.i_fields.opcode)
            cpu_pkg::op_rtype: begin
                e.dest = ins.r_fields.rd;
                case (ins.r_fields.func)
                    cpu_pkg::fn_add: e.alu_result = a + b;
                    cpu_pkg::fn_sub: e.alu_result = a - b;
                    cpu_pkg::fn_and: e.alu_result = a & b;
                    cpu_pkg::fn_or:  e.alu_result = a | b;
                    cpu_pkg::fn_xor: e.alu_result = a ^ b;
                    cpu_pkg::fn_slt: e.alu_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    cpu_pkg::fn_sll: e.alu_result = b << ins.r_fields.shamt;
                    cpu_pkg::fn_srl: e.alu_result = b >> ins.r_fields.shamt;
                    cpu_pkg::fn_sra: e.alu_result = $unsigned($signed(b) >>> ins.r_fields.shamt);
                    default:         e.alu_result = 32'd0;
                endcase
            end
            cpu_pkg::op_addi: e.alu_result = a + simm;
            cpu_pkg::op_slti: e.alu_result = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            cpu_pkg::op_andi: e.alu_result = a & zimm;
            cpu_pkg::op_ori:  e.alu_result = a | zimm;
            cpu_pkg::op_lui:  e.alu_result = {ins.i_fields.imm, 16'd0};
            cpu_pkg::op_lw: begin
                e.alu_result = a + simm;   // base plus offset
                e.memread = 1'b1;
                e.memtoreg = 1'b1;
            end
            cpu_pkg::op_sw: begin
                e.alu_result = a + simm;
                e.memwrite = 1'b1;
                e.regwrite = 1'b0;
            end
            default: e.regwrite = 1'b0;
        endcase
        return e;
    endfunction

    task automatic step_cycle;
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout, run went past %0d cycles", max_cycles);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_field(string name, logic [31:0] act, logic [31:0] expv);
        assert (act === expv) else begin
            errors++;
            $display("Fail %s expected 0x%08h actual 0x%08h", name, expv, act);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_outputs;
        check_field("ex.alu_result", ex.alu_result, exp_ex.alu_result);
        check_field("ex.store_data", ex.store_data, exp_ex.store_data);
        check_field("ex.dest", {27'd0, ex.dest}, {27'd0, exp_ex.dest});
        check_field("ex.regwrite", {31'd0, ex.regwrite}, {31'd0, exp_ex.regwrite});
        check_field("ex.memwrite", {31'd0, ex.memwrite}, {31'd0, exp_ex.memwrite});
        check_field("ex.memread", {31'd0, ex.memread}, {31'd0, exp_ex.memread});
        check_field("ex.memtoreg", {31'd0, ex.memtoreg}, {31'd0, exp_ex.memtoreg});
    endtask

    // small register range so writebacks and reads collide often
    task automatic drive_random;
        cpu_pkg::instr_u ins;
        logic [31:0]     r;
        ins = $urandom();
        r = $urandom();
        ins.i_fields.opcode = opcodes[r[2:0]];
        ins.i_fields.rs = {2'b00, r[6:4]};
        ins.i_fields.rt = {2'b00, r[10:8]};
        if (ins.i_fields.opcode == cpu_pkg::op_rtype) begin
            ins.r_fields.rd = r[16:12];
            ins.r_fields.func = funcs[r[23:20] % 4'd9];
        end
        exp_ex = model_ex(ins, shadow[ins.i_fields.rs], shadow[ins.i_fields.rt]);
        instr = ins;
        pc = pc + 32'd4;
        wb.wen = r[24];
        wb.waddr = {2'b00, r[27:25]};
        wb.wdata = $urandom();
        if (wb.wen && (wb.waddr != 5'd0)) begin
            shadow[wb.waddr] = wb.wdata;   // seen from the next instruction on
        end
    endtask

    initial begin
        errors = 0;
        cycles = 0;
        reset = 1'b1;
        pc = 32'd0;
        instr = '0;
        wb = '0;
        exp_ex = '0;   // cleared bundle executes as a zero add
        for (int k = 0; k < 32; k++) begin
            shadow[k] = 32'd0;
        end
        void'($urandom(32'h2f52_3bd6));
        // writebacks during reset must not land, so the file still reads zero
        for (int k = 0; k < 4; k++) begin
            wb.wen = 1'b1;
            wb.waddr = 5'(k + 1);
            wb.wdata = $urandom();
            step_cycle();
        end
        reset = 1'b0;
        check_outputs();
        for (int n = 0; n < num_instr; n++) begin
            drive_random();
            step_cycle();
            check_outputs();
        end
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

/* vlog.f */
design/cpu_pkg.sv
design/decode_stage.sv
design/id_ex.sv
design/execute_stage.sv
design/id_ex_path.sv
test/id_ex_path_asserts.sv
test/id_ex_path_tb.sv

/* run.sh */
#!/bin/sh
# build and run the id_ex_path testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module id_ex_path_tb -o sim_id_ex_path
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_id_ex_path > sim.log 2>&1
status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
